//--- hw/score_cfg.svh
`ifndef SCORE_CFG_SVH
`define SCORE_CFG_SVH

// play record slots are numbered 1 to SCORE_SLOTS.
`define SCORE_SLOTS 9

// characters in one text row of the history page.
`define ROW_CHARS 32

// characters in a chart name.
`define CHART_CHARS 16

// clk cycles per blink phase of the cursor digit.
`define BLINK_DIV 16

`endif

//--- hw/game_pkg.sv
`include "score_cfg.svh"

package game_pkg;

    typedef logic [3:0] user_id_t;

    // scores stay within 0 to 99999, so five decimal digits cover them.
    typedef logic [16:0] score_t;

    typedef logic [`CHART_CHARS*8-1:0] chart_name_t;

    typedef struct packed {
        user_id_t    user_id;
        score_t      score;
        chart_name_t chart_name;
    } play_record_t;

    // slot 0 is not a record; valid slots run from 1 to SCORE_SLOTS.
    typedef logic [3:0] slot_t;

    function automatic logic slot_ok(slot_t s);
        return (s >= slot_t'(1)) && (s <= slot_t'(`SCORE_SLOTS));
    endfunction

endpackage

//--- hw/screen_pkg.sv
`include "score_cfg.svh"

package screen_pkg;

    // the leftmost character sits in the most significant byte.
    typedef logic [`ROW_CHARS*8-1:0] text_row_t;

    typedef logic [3:0] arrow_t;

    localparam arrow_t KEY_UP    = 4'b1000;
    localparam arrow_t KEY_DOWN  = 4'b0100;
    localparam arrow_t KEY_LEFT  = 4'b0010;
    localparam arrow_t KEY_RIGHT = 4'b0001;

    typedef enum logic {
        PAGE_HISTORY,
        PAGE_MENU
    } page_state_t;

    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_BAR   = 8'h7c;
    localparam logic [7:0] CHAR_ZERO  = 8'h30;

    localparam text_row_t BLANK_ROW = {`ROW_CHARS{CHAR_SPACE}};

endpackage

//--- hw/record_wb_if.sv
interface record_wb_if;
    import game_pkg::*;

    logic         cyc;
    logic         stb;
    logic         we;
    slot_t        adr;
    play_record_t dat_r;
    logic         ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        output dat_r,
        output ack
    );

endinterface

//--- hw/record_store.sv
`include "score_cfg.svh"

module record_store (
    input  logic                   clk,
    input  logic                   rst,
    record_wb_if.slave             wb,
    input  logic                   wr_en,
    input  game_pkg::slot_t        wr_slot,
    input  game_pkg::play_record_t wr_data
);
    import game_pkg::*;

    play_record_t mem [1:`SCORE_SLOTS];
    logic         rd_req;

    // a new request is one that has not been acknowledged yet.
    assign rd_req = wb.cyc && wb.stb && !wb.ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i <= `SCORE_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en && slot_ok(wr_slot)) begin
            mem[wr_slot] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb.ack <= 1'b0;
        end else begin
            wb.ack <= rd_req;
        end
    end

    // bus writes get an ack but leave the records alone.
    always_ff @(posedge clk) begin
        if (rd_req) begin
            if (!wb.we && slot_ok(wb.adr)) begin
                wb.dat_r <= mem[wb.adr];
            end else begin
                wb.dat_r <= '0;
            end
        end
    end

endmodule

//--- hw/history_nav.sv
`include "score_cfg.svh"

module history_nav (
    input  logic                    clk,
    input  logic                    rst,
    input  screen_pkg::arrow_t      keys,
    output game_pkg::slot_t         cursor,
    output screen_pkg::page_state_t page_state
);
    import game_pkg::*;
    import screen_pkg::*;

    arrow_t keys_q;
    arrow_t keys_qq;
    arrow_t press;

    // keys_q is the sampled key state and keys_qq the one before it.
    assign press = keys_q & ~keys_qq;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keys_q     <= '0;
            keys_qq    <= '0;
            cursor     <= slot_t'(1);
            page_state <= PAGE_HISTORY;
        end else begin
            keys_q  <= keys;
            keys_qq <= keys_q;
            // anything but a single new press falls into the default.
            case (press)
                KEY_UP: begin
                    if (page_state == PAGE_HISTORY) begin
                        cursor <= (cursor == slot_t'(1)) ? slot_t'(`SCORE_SLOTS)
                                                         : cursor - slot_t'(1);
                    end
                end
                KEY_DOWN: begin
                    if (page_state == PAGE_HISTORY) begin
                        cursor <= (cursor == slot_t'(`SCORE_SLOTS)) ? slot_t'(1)
                                                                    : cursor + slot_t'(1);
                    end
                end
                KEY_LEFT: page_state <= PAGE_MENU;
                KEY_RIGHT: page_state <= PAGE_HISTORY;
                default: ;
            endcase
        end
    end

endmodule

//--- hw/history_row_fmt.sv
`include "score_cfg.svh"

module history_row_fmt (
    input  logic                  clk,
    input  logic                  rst,
    record_wb_if.master           wb,
    input  game_pkg::slot_t       cursor,
    output logic                  row_we,
    output game_pkg::slot_t       row_addr,
    output screen_pkg::text_row_t row_data
);
    import game_pkg::*;
    import screen_pkg::*;

    localparam int SCORE_BITS = $bits(score_t);
    localparam int BLINK_W    = $clog2(`BLINK_DIV);

    typedef enum logic [1:0] {
        S_BUS,
        S_SHIFT,
        S_BUILD,
        S_WRITE
    } fmt_state_t;

    fmt_state_t           state;
    slot_t                slot;
    logic                 bus_req;
    logic [4:0]           shift_cnt;
    logic [19:0]          bcd;
    logic [19:0]          bcd_adj;
    score_t               bin;
    play_record_t         rec;
    logic [BLINK_W-1:0]   blink_cnt;
    logic                 blink_on;
    logic [7:0]           slot_char;

    function automatic logic [7:0] digit_char(logic [3:0] v);
        return CHAR_ZERO + {4'h0, v};
    endfunction

    // double-dabble correction applied before each shift.
    function automatic logic [19:0] dabble_adj(logic [19:0] b);
        logic [19:0] r;
        for (int d = 0; d < 5; d++) begin
            r[d*4 +: 4] = (b[d*4 +: 4] >= 4'd5) ? b[d*4 +: 4] + 4'd3 : b[d*4 +: 4];
        end
        return r;
    endfunction

    // leading zeros become spaces but the units digit is always shown.
    function automatic logic [39:0] score_text(logic [19:0] b);
        logic [39:0] t;
        logic        lead;
        lead = 1'b1;
        for (int d = 4; d >= 0; d--) begin
            if (lead && d != 0 && b[d*4 +: 4] == 4'd0) begin
                t[d*8 +: 8] = CHAR_SPACE;
            end else begin
                lead        = 1'b0;
                t[d*8 +: 8] = digit_char(b[d*4 +: 4]);
            end
        end
        return t;
    endfunction

    function automatic chart_name_t chart_text(chart_name_t name);
        chart_name_t t;
        for (int i = 0; i < `CHART_CHARS; i++) begin
            t[i*8 +: 8] = (name[i*8 +: 8] == 8'h00) ? CHAR_SPACE : name[i*8 +: 8];
        end
        return t;
    endfunction

    assign wb.cyc   = bus_req;
    assign wb.stb   = bus_req;
    assign wb.we    = 1'b0;
    assign wb.adr   = slot;
    assign row_addr = slot;

    assign bcd_adj   = dabble_adj(bcd);
    assign slot_char = (slot == cursor && !blink_on) ? CHAR_SPACE : digit_char(slot);

    // reset lands in S_WRITE with row_we low, so the first sweep opens at slot 1.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_WRITE;
            slot      <= slot_t'(`SCORE_SLOTS);
            bus_req   <= 1'b0;
            row_we    <= 1'b0;
            shift_cnt <= '0;
        end else begin
            case (state)
                S_BUS: begin
                    if (wb.ack) begin
                        bus_req   <= 1'b0;
                        shift_cnt <= '0;
                        state     <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    shift_cnt <= shift_cnt + 5'd1;
                    if (shift_cnt == 5'(SCORE_BITS - 1)) begin
                        state <= S_BUILD;
                    end
                end
                S_BUILD: begin
                    row_we <= 1'b1;
                    state  <= S_WRITE;
                end
                default: begin
                    row_we  <= 1'b0;
                    slot    <= (slot == slot_t'(`SCORE_SLOTS)) ? slot_t'(1) : slot + slot_t'(1);
                    bus_req <= 1'b1;
                    state   <= S_BUS;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_BUS && wb.ack) begin
            rec <= wb.dat_r;
            bcd <= '0;
            bin <= wb.dat_r.score;
        end else if (state == S_SHIFT) begin
            {bcd, bin} <= {bcd_adj[18:0], bin, 1'b0};
        end
        if (state == S_BUILD) begin
            row_data <= {CHAR_SPACE, slot_char, CHAR_BAR, "User", digit_char(rec.user_id),
                         CHAR_SPACE, CHAR_BAR, chart_text(rec.chart_name), CHAR_BAR,
                         score_text(bcd)};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink_cnt <= '0;
            blink_on  <= 1'b1;
        end else if (blink_cnt == BLINK_W'(`BLINK_DIV - 1)) begin
            blink_cnt <= '0;
            blink_on  <= ~blink_on;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

endmodule

//--- hw/line_buffer.sv
`include "score_cfg.svh"

module line_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  game_pkg::slot_t       wr_slot,
    input  screen_pkg::text_row_t wr_row,
    input  game_pkg::slot_t       rd_slot,
    output screen_pkg::text_row_t rd_row
);
    import game_pkg::*;
    import screen_pkg::*;

    text_row_t rows [1:`SCORE_SLOTS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i <= `SCORE_SLOTS; i++) begin
                rows[i] <= BLANK_ROW;
            end
        end else if (we && slot_ok(wr_slot)) begin
            rows[wr_slot] <= wr_row;
        end
    end

    // the display sees its row one cycle after it presents rd_slot.
    always_ff @(posedge clk) begin
        rd_row <= slot_ok(rd_slot) ? rows[rd_slot] : BLANK_ROW;
    end

endmodule

//--- hw/score_history_top.sv
module score_history_top (
    input  logic                    clk,
    input  logic                    rst,
    input  screen_pkg::arrow_t      keys,
    input  logic                    rec_we,
    input  game_pkg::slot_t         rec_slot,
    input  game_pkg::play_record_t  rec_data,
    input  game_pkg::slot_t         rd_slot,
    output screen_pkg::text_row_t   rd_row,
    output game_pkg::slot_t         cursor,
    output screen_pkg::page_state_t page_state
);
    import game_pkg::*;
    import screen_pkg::*;

    logic      row_we;
    slot_t     row_addr;
    text_row_t row_data;

    record_wb_if wb_link ();

    record_store u_store (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb_link.slave),
        .wr_en   (rec_we),
        .wr_slot (rec_slot),
        .wr_data (rec_data)
    );

    history_nav u_nav (
        .clk        (clk),
        .rst        (rst),
        .keys       (keys),
        .cursor     (cursor),
        .page_state (page_state)
    );

    history_row_fmt u_fmt (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb_link.master),
        .cursor   (cursor),
        .row_we   (row_we),
        .row_addr (row_addr),
        .row_data (row_data)
    );

    line_buffer u_buf (
        .clk     (clk),
        .rst     (rst),
        .we      (row_we),
        .wr_slot (row_addr),
        .wr_row  (row_data),
        .rd_slot (rd_slot),
        .rd_row  (rd_row)
    );

endmodule

//--- verification/score_history_props.sv
`include "score_cfg.svh"

module score_history_props (
    input logic                    clk,
    input logic                    rst,
    input screen_pkg::arrow_t      keys,
    input game_pkg::slot_t         cursor,
    input screen_pkg::page_state_t page_state,
    input logic                    cyc,
    input logic                    stb,
    input logic                    we,
    input logic                    ack
);
    import game_pkg::*;
    import screen_pkg::*;

    arrow_t keys_q;
    arrow_t keys_qq;
    arrow_t press;
    logic   moving;

    // a press is a key that is high now and was low one sample before.
    assign press  = keys_q & ~keys_qq;
    assign moving = (page_state == PAGE_HISTORY) && (press == KEY_UP || press == KEY_DOWN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keys_q  <= '0;
            keys_qq <= '0;
        end else begin
            keys_q  <= keys;
            keys_qq <= keys_q;
        end
    end

    a_up_step: assert property (@(posedge clk) disable iff (rst)
        (press == KEY_UP && page_state == PAGE_HISTORY) |=>
        cursor == (($past(cursor) == slot_t'(1)) ? slot_t'(`SCORE_SLOTS)
                                                 : $past(cursor) - slot_t'(1)))
        else $error("cursor did not step back by one on an up press");

    a_down_step: assert property (@(posedge clk) disable iff (rst)
        (press == KEY_DOWN && page_state == PAGE_HISTORY) |=>
        cursor == (($past(cursor) == slot_t'(`SCORE_SLOTS)) ? slot_t'(1)
                                                            : $past(cursor) + slot_t'(1)))
        else $error("cursor did not step forward by one on a down press");

    // a held key or a press on the menu page leaves the cursor where it is.
    a_cursor_still: assert property (@(posedge clk) disable iff (rst)
        !moving |=> $stable(cursor))
        else $error("cursor moved without a new up or down press");

    a_left_menu: assert property (@(posedge clk) disable iff (rst)
        press == KEY_LEFT |=> page_state == PAGE_MENU)
        else $error("left press did not open the menu page");

    a_right_history: assert property (@(posedge clk) disable iff (rst)
        press == KEY_RIGHT |=> page_state == PAGE_HISTORY)
        else $error("right press did not return to the history page");

    a_page_still: assert property (@(posedge clk) disable iff (rst)
        (press != KEY_LEFT && press != KEY_RIGHT) |=> $stable(page_state))
        else $error("page state changed without a left or right press");

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        (cyc && stb && !ack) |=> (ack && cyc && stb))
        else $error("wishbone request not acknowledged in the next cycle");

    a_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb))
        else $error("wishbone ack without a request in the cycle before");

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
        else $error("wishbone ack lasted longer than one cycle");

    a_no_write: assert property (@(posedge clk) disable iff (rst)
        !we)
        else $error("wishbone write enable raised on the record link");

endmodule

bind score_history_top score_history_props u_props (
    .clk        (clk),
    .rst        (rst),
    .keys       (keys),
    .cursor     (cursor),
    .page_state (page_state),
    .cyc        (wb_link.cyc),
    .stb        (wb_link.stb),
    .we         (wb_link.we),
    .ack        (wb_link.ack)
);

//--- verification/score_history_tb.sv
`include "score_cfg.svh"

module score_history_tb;
    import game_pkg::*;
    import screen_pkg::*;

    localparam int CLK_HALF    = 4;
    localparam int SLOT_CYCLES = 21;
    localparam int WAIT_CYCLES = 2 * `SCORE_SLOTS * SLOT_CYCLES;
    localparam int READ_CYCLES = 2 * `SCORE_SLOTS + 2;
    localparam int KEY_CYCLES  = 12;
    localparam int RUN_CYCLES  = 10 + 4 * READ_CYCLES + 3 * WAIT_CYCLES + 8 * KEY_CYCLES
                                 + 2 * (`SCORE_SLOTS + 1);

    logic         clk;
    logic         rst;
    arrow_t       keys;
    logic         rec_we;
    slot_t        rec_slot;
    play_record_t rec_data;
    slot_t        rd_slot;
    text_row_t    rd_row;
    slot_t        cursor;
    page_state_t  page_state;

    play_record_t model [1:`SCORE_SLOTS];
    slot_t        model_cursor;
    page_state_t  model_page;
    logic [31:0]  lcg_seed;

    score_history_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .keys       (keys),
        .rec_we     (rec_we),
        .rec_slot   (rec_slot),
        .rec_data   (rec_data),
        .rd_slot    (rd_slot),
        .rd_row     (rd_row),
        .cursor     (cursor),
        .page_state (page_state)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_seed = lcg_seed * 32'd1664525 + 32'd1013904223;
        return lcg_seed;
    endfunction

    // chart names mix upper and lower case letters and leave about one byte in five at zero.
    function automatic play_record_t random_record();
        play_record_t r;
        logic [31:0]  v;
        r.user_id = user_id_t'((next_rand() >> 16) % 10);
        r.score   = score_t'((next_rand() >> 8) % 100000);
        for (int i = 0; i < `CHART_CHARS; i++) begin
            v = next_rand() >> 16;
            if (v % 5 == 0) begin
                r.chart_name[i*8 +: 8] = 8'h00;
            end else begin
                r.chart_name[i*8 +: 8] = ((v & 32'h100) != 0) ? 8'(8'h61 + v % 26)
                                                             : 8'(8'h41 + v % 26);
            end
        end
        return r;
    endfunction

    // column 0 is the leftmost character of the row.
    function automatic text_row_t expected_row(slot_t s, play_record_t r, logic digit_shown);
        logic [7:0]  cols [0:`ROW_CHARS-1];
        logic [7:0]  ch;
        int unsigned value;
        text_row_t   row;
        cols[0] = 8'h20;
        cols[1] = digit_shown ? 8'(8'h30 + s) : 8'h20;
        cols[2] = "|";
        cols[3] = "U";
        cols[4] = "s";
        cols[5] = "e";
        cols[6] = "r";
        cols[7] = 8'(8'h30 + r.user_id);
        cols[8] = 8'h20;
        cols[9] = "|";
        for (int i = 0; i < `CHART_CHARS; i++) begin
            ch           = r.chart_name[(`CHART_CHARS - 1 - i)*8 +: 8];
            cols[10 + i] = (ch == 8'h00) ? 8'h20 : ch;
        end
        cols[26] = "|";
        value = r.score;
        for (int c = `ROW_CHARS - 1; c >= 27; c--) begin
            cols[c] = (c == `ROW_CHARS - 1 || value != 0) ? 8'(8'h30 + value % 10) : 8'h20;
            value   = value / 10;
        end
        for (int c = 0; c < `ROW_CHARS; c++) begin
            row[(`ROW_CHARS - 1 - c)*8 +: 8] = cols[c];
        end
        return row;
    endfunction

    task automatic read_row(input slot_t s);
        @(posedge clk);
        rd_slot <= s;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_blank_rows();
        text_row_t blank;
        blank = {`ROW_CHARS{8'h20}};
        for (int s = 1; s <= `SCORE_SLOTS; s++) begin
            read_row(slot_t'(s));
            assert (rd_row == blank) else
                fail_now($sformatf(
                    "mismatch at time %0t: rd_row slot %0d got \"%s\" expected \"%s\"",
                    $time, s, rd_row, blank));
        end
    endtask

    // the cursor row may be caught in either blink phase.
    task automatic check_rows();
        text_row_t exp_on;
        text_row_t exp_off;
        for (int s = 1; s <= `SCORE_SLOTS; s++) begin
            exp_on  = expected_row(slot_t'(s), model[s], 1'b1);
            exp_off = expected_row(slot_t'(s), model[s], 1'b0);
            read_row(slot_t'(s));
            assert (rd_row == exp_on || (slot_t'(s) == model_cursor && rd_row == exp_off)) else
                fail_now($sformatf(
                    "mismatch at time %0t: rd_row slot %0d got \"%s\" expected \"%s\"",
                    $time, s, rd_row, exp_on));
        end
    endtask

    task automatic write_record(input slot_t s, input play_record_t r);
        @(posedge clk);
        rec_we   <= 1'b1;
        rec_slot <= s;
        rec_data <= r;
        @(posedge clk);
        rec_we   <= 1'b0;
        model[s] = r;
    endtask

    task automatic check_nav_state();
        assert (cursor == model_cursor) else
            fail_now($sformatf("mismatch at time %0t: cursor got %0d expected %0d",
                               $time, cursor, model_cursor));
        assert (page_state == model_page) else
            fail_now($sformatf("mismatch at time %0t: page_state got %0d expected %0d",
                               $time, page_state, model_page));
    endtask

    task automatic press_key(input arrow_t k, input int hold);
        @(posedge clk);
        keys <= k;
        repeat (hold) @(posedge clk);
        keys <= '0;
        repeat (3) @(posedge clk);
        if (k == KEY_LEFT) begin
            model_page = PAGE_MENU;
        end else if (k == KEY_RIGHT) begin
            model_page = PAGE_HISTORY;
        end else if (model_page == PAGE_HISTORY && k == KEY_UP) begin
            model_cursor = (model_cursor == slot_t'(1)) ? slot_t'(`SCORE_SLOTS)
                                                        : model_cursor - slot_t'(1);
        end else if (model_page == PAGE_HISTORY && k == KEY_DOWN) begin
            model_cursor = (model_cursor == slot_t'(`SCORE_SLOTS)) ? slot_t'(1)
                                                                   : model_cursor + slot_t'(1);
        end
        @(negedge clk);
        check_nav_state();
    endtask

    initial begin
        repeat (RUN_CYCLES + 200) @(posedge clk);
        $display("timeout after %0d cycles, the test sequence did not finish", RUN_CYCLES + 200);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        play_record_t r;
        rst          = 1'b1;
        keys         = '0;
        rec_we       = 1'b0;
        rec_slot     = '0;
        rec_data     = '0;
        rd_slot      = slot_t'(1);
        lcg_seed     = 32'h7ef0;
        model_cursor = slot_t'(1);
        model_page   = PAGE_HISTORY;
        for (int s = 1; s <= `SCORE_SLOTS; s++) begin
            model[s] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // the first formatted row lands about 22 cycles after reset.
        @(negedge clk);
        check_nav_state();
        check_blank_rows();

        for (int s = 1; s <= `SCORE_SLOTS; s++) begin
            r = random_record();
            if (s == 1) r.score = score_t'(0);
            if (s == 2) r.score = score_t'(7);
            if (s == 3) r.score = score_t'(99999);
            write_record(slot_t'(s), r);
        end
        repeat (WAIT_CYCLES) @(posedge clk);
        check_rows();

        press_key(KEY_UP, 6);
        press_key(KEY_DOWN, 1);
        press_key(KEY_DOWN, 1);
        press_key(KEY_DOWN, 3);
        press_key(KEY_LEFT, 1);
        press_key(KEY_UP, 1);
        press_key(KEY_RIGHT, 1);
        repeat (WAIT_CYCLES) @(posedge clk);
        check_rows();

        r = random_record();
        write_record(slot_t'(5), r);
        repeat (WAIT_CYCLES) @(posedge clk);
        check_rows();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- score_history.f
+incdir+hw
hw/game_pkg.sv
hw/screen_pkg.sv
hw/record_wb_if.sv
hw/record_store.sv
hw/history_nav.sv
hw/history_row_fmt.sv
hw/line_buffer.sv
hw/score_history_top.sv
verification/score_history_props.sv
verification/score_history_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= score_history_tb
FILELIST  ?= score_history.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
